//--- rtl/viterbi_pkg.sv
package viterbi_pkg;

  // Rate 1/2, K = 7 code
  localparam int CONSTRAINT_LEN = 7;
  localparam int NUM_STATES     = 2 ** (CONSTRAINT_LEN - 1);

  localparam logic [CONSTRAINT_LEN-1:0] POLY_G0 = 7'o171; // I bit
  localparam logic [CONSTRAINT_LEN-1:0] POLY_G1 = 7'o133; // Q bit

  localparam int SOFT_WIDTH = 8;
  localparam int BM_WIDTH   = 9;  // Two 8-bit distances summed
  localparam int SM_WIDTH   = 16;

  // Unknown start state is biased away from state 0
  localparam int INIT_BIAS = 2 ** 10;

  typedef logic signed [SOFT_WIDTH-1:0]     soft_t;
  typedef logic        [SOFT_WIDTH-1:0]     ubyte_t;
  typedef logic        [BM_WIDTH-1:0]       bm_t;
  typedef logic        [SM_WIDTH-1:0]       sm_t;
  typedef logic        [CONSTRAINT_LEN-2:0] state_t;
  typedef logic        [NUM_STATES-1:0]     decision_t;

  typedef enum logic {
    PHASE_I,
    PHASE_Q
  } pair_phase_e;

  // Encoder outputs {I, Q} when in_bit enters a register holding prev_state
  // Newest bit sits in the MSB of the window
  function automatic logic [1:0] code_bits(input state_t prev_state, input logic in_bit);
    logic [CONSTRAINT_LEN-1:0] window;
    window = {in_bit, prev_state};
    return {^(window & POLY_G0), ^(window & POLY_G1)};
  endfunction

endpackage

//--- rtl/branch_metric_if.sv
interface branch_metric_if;

  logic             valid;
  logic             ready;
  viterbi_pkg::bm_t bm_00; // Expected I = 0, Q = 0
  viterbi_pkg::bm_t bm_01;
  viterbi_pkg::bm_t bm_10;
  viterbi_pkg::bm_t bm_11;

  modport src (
    output valid,
    output bm_00,
    output bm_01,
    output bm_10,
    output bm_11,
    input  ready
  );

  modport dst (
    input  valid,
    input  bm_00,
    input  bm_01,
    input  bm_10,
    input  bm_11,
    output ready
  );

endinterface

//--- rtl/symbol_pair.sv
module symbol_pair (
  input  logic                clk,
  input  logic                sys_rst,
  input  viterbi_pkg::soft_t  soft_in,
  input  logic                soft_valid,
  output logic                soft_ready,
  output logic                pair_valid,
  input  logic                pair_ready,
  output viterbi_pkg::ubyte_t pair_i,
  output viterbi_pkg::ubyte_t pair_q
);

  viterbi_pkg::pair_phase_e phase;
  viterbi_pkg::ubyte_t      i_hold;
  viterbi_pkg::ubyte_t      sample_ub;
  logic                     take;

  // Sign flip maps -128..127 onto 0..255
  assign sample_ub = {~soft_in[viterbi_pkg::SOFT_WIDTH-1], soft_in[viterbi_pkg::SOFT_WIDTH-2:0]};

  // Stall both samples while a finished pair is still waiting
  assign soft_ready = !pair_valid || pair_ready;
  assign take       = soft_valid && soft_ready;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      phase      <= viterbi_pkg::PHASE_I;
      pair_valid <= 1'b0;
    end else begin
      if (pair_ready) begin
        pair_valid <= 1'b0;
      end
      if (take) begin
        if (phase == viterbi_pkg::PHASE_Q) begin
          pair_valid <= 1'b1;
          phase      <= viterbi_pkg::PHASE_I;
        end else begin
          phase <= viterbi_pkg::PHASE_Q;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (phase == viterbi_pkg::PHASE_I) begin
        i_hold <= sample_ub;
      end else begin
        pair_i <= i_hold;
        pair_q <= sample_ub;
      end
    end
  end

endmodule

//--- rtl/branch_metric.sv
module branch_metric (
  input  logic                clk,
  input  logic                sys_rst,
  input  logic                pair_valid,
  output logic                pair_ready,
  input  viterbi_pkg::ubyte_t pair_i,
  input  viterbi_pkg::ubyte_t pair_q,
  branch_metric_if.src        bm
);

  viterbi_pkg::bm_t dist0_i;
  viterbi_pkg::bm_t dist1_i;
  viterbi_pkg::bm_t dist0_q;
  viterbi_pkg::bm_t dist1_q;
  logic             take;

  // Distance to a 0 is the sample itself
  assign dist0_i = {1'b0, pair_i};
  assign dist0_q = {1'b0, pair_q};
  // 255 - x is the bitwise inverse of an 8-bit value
  assign dist1_i = {1'b0, ~pair_i};
  assign dist1_q = {1'b0, ~pair_q};

  assign pair_ready = !bm.valid || bm.ready;
  assign take       = pair_valid && pair_ready;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      bm.valid <= 1'b0;
    end else begin
      if (bm.ready) begin
        bm.valid <= 1'b0;
      end
      if (take) begin
        bm.valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      bm.bm_00 <= dist0_i + dist0_q;
      bm.bm_01 <= dist0_i + dist1_q;
      bm.bm_10 <= dist1_i + dist0_q;
      bm.bm_11 <= dist1_i + dist1_q;
    end
  end

endmodule

//--- rtl/acs_array.sv
module acs_array (
  input  logic                   clk,
  input  logic                   sys_rst,
  branch_metric_if.dst           bm,
  output logic                   dec_valid,
  input  logic                   dec_ready,
  output viterbi_pkg::decision_t decisions
);

  localparam int NS = viterbi_pkg::NUM_STATES;
  localparam int SW = viterbi_pkg::SM_WIDTH;

  viterbi_pkg::sm_t       sm     [NS];
  viterbi_pkg::sm_t       new_sm [NS];
  viterbi_pkg::bm_t       bm_vec [4];
  viterbi_pkg::decision_t dec_bit;
  logic [NS-1:0]          msb_set;
  logic                   norm;
  logic                   take;

  // Indexed by the expected {I, Q} bits
  assign bm_vec[0] = bm.bm_00;
  assign bm_vec[1] = bm.bm_01;
  assign bm_vec[2] = bm.bm_10;
  assign bm_vec[3] = bm.bm_11;

  assign bm.ready = !dec_valid || dec_ready;
  assign take     = bm.valid && bm.ready;

  for (genvar s = 0; s < NS; s++) begin : g_acs
    // Predecessors are s shifted left with 0 or 1 appended
    localparam viterbi_pkg::state_t P0 = viterbi_pkg::state_t'((2 * s) % NS);
    localparam viterbi_pkg::state_t P1 = viterbi_pkg::state_t'((2 * s + 1) % NS);
    localparam logic IN_BIT = (s >= NS / 2); // New bit lands in the MSB
    localparam logic [1:0] C0 = viterbi_pkg::code_bits(P0, IN_BIT);
    localparam logic [1:0] C1 = viterbi_pkg::code_bits(P1, IN_BIT);

    viterbi_pkg::sm_t sum0;
    viterbi_pkg::sm_t sum1;

    assign sum0 = sm[P0] + viterbi_pkg::sm_t'(bm_vec[C0]);
    assign sum1 = sm[P1] + viterbi_pkg::sm_t'(bm_vec[C1]);

    // Tie goes to the even predecessor
    assign dec_bit[s] = (sum1 < sum0);
    assign new_sm[s]  = dec_bit[s] ? sum1 : sum0;
    assign msb_set[s] = new_sm[s][SW-1];
  end

  // Every metric in the upper half, drop half the range
  assign norm = &msb_set;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int s = 0; s < NS; s++) begin
        sm[s] <= (s == 0) ? '0 : viterbi_pkg::sm_t'(viterbi_pkg::INIT_BIAS);
      end
      dec_valid <= 1'b0;
    end else begin
      if (dec_ready) begin
        dec_valid <= 1'b0;
      end
      if (take) begin
        for (int s = 0; s < NS; s++) begin
          if (norm) begin
            sm[s] <= {1'b0, new_sm[s][SW-2:0]};
          end else begin
            sm[s] <= new_sm[s];
          end
        end
        dec_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      decisions <= dec_bit;
    end
  end

endmodule

//--- rtl/survivor_exchange.sv
module survivor_exchange #(
  parameter int DECODE_DEPTH = 42
) (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  logic                   dec_valid,
  output logic                   dec_ready,
  input  viterbi_pkg::decision_t decisions,
  output logic                   bit_out,
  output logic                   bit_valid,
  input  logic                   bit_ready
);

  localparam int NS         = viterbi_pkg::NUM_STATES;
  localparam int FILL_WIDTH = $clog2(DECODE_DEPTH + 1);

  // Newest decoded bit in the LSB of each path
  logic [DECODE_DEPTH-1:0] paths      [NS];
  logic [DECODE_DEPTH-1:0] paths_next [NS];
  logic [FILL_WIDTH-1:0]   fill;
  logic                    full;
  logic                    oldest_bit;
  logic                    take;

  assign dec_ready = !bit_valid || bit_ready;
  assign take      = dec_valid && dec_ready;
  assign full      = (fill == FILL_WIDTH'(DECODE_DEPTH));

  always_comb begin
    viterbi_pkg::state_t pred;
    logic                in_bit;
    for (int s = 0; s < NS; s++) begin
      pred          = viterbi_pkg::state_t'(2 * s) | viterbi_pkg::state_t'(decisions[s]);
      in_bit        = (s >= NS / 2);
      paths_next[s] = {paths[pred][DECODE_DEPTH-2:0], in_bit};
    end
  end

  // Bit that falls off state 0's survivor on this update
  assign oldest_bit = paths[viterbi_pkg::state_t'(decisions[0])][DECODE_DEPTH-1];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      fill      <= '0;
      bit_valid <= 1'b0;
    end else begin
      if (bit_ready) begin
        bit_valid <= 1'b0;
      end
      if (take) begin
        if (full) begin
          bit_valid <= 1'b1;
        end else begin
          fill <= fill + FILL_WIDTH'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      paths <= paths_next;
      if (full) begin
        bit_out <= oldest_bit;
      end
    end
  end

endmodule

//--- rtl/viterbi_top.sv
module viterbi_top #(
  parameter int DECODE_DEPTH = 42
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  viterbi_pkg::soft_t soft_in,
  input  logic               soft_valid,
  output logic               soft_ready,
  output logic               bit_out,
  output logic               bit_valid,
  input  logic               bit_ready
);

  logic                   pair_valid;
  logic                   pair_ready;
  viterbi_pkg::ubyte_t    pair_i;
  viterbi_pkg::ubyte_t    pair_q;
  logic                   dec_valid;
  logic                   dec_ready;
  viterbi_pkg::decision_t decisions;

  branch_metric_if bm_bus ();

  symbol_pair u_symbol_pair (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .soft_in    (soft_in),
    .soft_valid (soft_valid),
    .soft_ready (soft_ready),
    .pair_valid (pair_valid),
    .pair_ready (pair_ready),
    .pair_i     (pair_i),
    .pair_q     (pair_q)
  );

  branch_metric u_branch_metric (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .pair_valid (pair_valid),
    .pair_ready (pair_ready),
    .pair_i     (pair_i),
    .pair_q     (pair_q),
    .bm         (bm_bus.src)
  );

  acs_array u_acs_array (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .bm        (bm_bus.dst),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .decisions (decisions)
  );

  survivor_exchange #(
    .DECODE_DEPTH (DECODE_DEPTH)
  ) u_survivor_exchange (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .decisions (decisions),
    .bit_out   (bit_out),
    .bit_valid (bit_valid),
    .bit_ready (bit_ready)
  );

endmodule

//--- verif/viterbi_assert.sv
module viterbi_assert (
  input logic clk,
  input logic sys_rst,
  input logic soft_ready,
  input logic bit_out,
  input logic bit_valid,
  input logic bit_ready,
  input logic exp_head,   // Oldest source bit not yet decoded
  input logic exp_empty
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  a_reset_idle: assert property (@(posedge clk) sys_rst |=> !bit_valid)
    else begin
      fail_count++;
      $error("Error at %0t: bit_valid high during or right after reset", $time);
    end

  a_reset_ready: assert property (@(posedge clk) sys_rst |=> soft_ready)
    else begin
      fail_count++;
      $error("Error at %0t: soft_ready low after reset", $time);
    end

  // Every accepted bit must match the next source bit in order
  a_bit_match: assert property (@(posedge clk) disable iff (sys_rst)
    bit_valid && bit_ready |-> !exp_empty && (bit_out == exp_head))
    else begin
      fail_count++;
      $error("Error at %0t: decoded bit %0b, expected %0b (queue empty %0b)",
             $time, bit_out, exp_head, exp_empty);
    end

  a_bit_hold: assert property (@(posedge clk) disable iff (sys_rst)
    bit_valid && !bit_ready |=> bit_valid && $stable(bit_out))
    else begin
      fail_count++;
      $error("Error at %0t: stalled output bit dropped or changed", $time);
    end

  a_bit_known: assert property (@(posedge clk) disable iff (sys_rst)
    bit_valid |-> !$isunknown(bit_out))
    else begin
      fail_count++;
      $error("Error at %0t: bit_out unknown while bit_valid is high", $time);
    end

endmodule

//--- verif/tb_viterbi.sv
module tb_viterbi;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DECODE_DEPTH = 42;
  localparam int WAIT_LIMIT   = 2000; // Cycles per wait loop

  logic               clk;
  logic               sys_rst;
  viterbi_pkg::soft_t soft_in;
  logic               soft_valid;
  logic               soft_ready;
  logic               bit_out;
  logic               bit_valid;
  logic               bit_ready;

  logic                exp_q[$];         // Source bits in send order
  logic                exp_head  = 1'b0;
  logic                exp_empty = 1'b1;
  int                  rd_idx    = 0;    // Next source bit the decoder owes
  int                  bits_out  = 0;
  logic                in_take   = 1'b0;
  int                  ready_low_pct;
  int                  timeout_count;
  int                  errors;
  bit                  aborted;
  viterbi_pkg::state_t enc_state;

  viterbi_top #(
    .DECODE_DEPTH (DECODE_DEPTH)
  ) uut (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .soft_in    (soft_in),
    .soft_valid (soft_valid),
    .soft_ready (soft_ready),
    .bit_out    (bit_out),
    .bit_valid  (bit_valid),
    .bit_ready  (bit_ready)
  );

  bind viterbi_top viterbi_assert u_check (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .soft_ready (soft_ready),
    .bit_out    (bit_out),
    .bit_valid  (bit_valid),
    .bit_ready  (bit_ready),
    .exp_head   (tb_viterbi.exp_head),
    .exp_empty  (tb_viterbi.exp_empty)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) in_take <= soft_valid && soft_ready;

  // Advance the read point on each output handshake
  always @(posedge clk) begin : track_output
    int next_idx;
    next_idx = rd_idx;
    if (sys_rst) begin
      next_idx = 0;
    end else if (bit_valid && bit_ready) begin
      next_idx = rd_idx + 1;
      bits_out <= bits_out + 1;
    end
    rd_idx <= next_idx;
    if (next_idx < exp_q.size()) begin
      exp_head  <= exp_q[next_idx];
      exp_empty <= 1'b0;
    end else begin
      exp_head  <= 1'b0;
      exp_empty <= 1'b1;
    end
  end

  // Random sink stalls
  initial begin
    bit_ready = 1'b1;
    forever begin
      @(negedge clk);
      bit_ready = (int'($urandom_range(99)) >= ready_low_pct);
    end
  end

  function automatic viterbi_pkg::soft_t soft_value(input logic b, input int weak_pct,
                                                    input bit erase_on);
    int                 mag;
    viterbi_pkg::soft_t value;
    if (int'($urandom_range(99)) >= weak_pct) begin
      value = b ? viterbi_pkg::soft_t'(127) : viterbi_pkg::soft_t'(-128);
    end else if (erase_on && $urandom_range(1) == 1) begin
      value = viterbi_pkg::soft_t'(-1); // Erasure just below the midpoint
    end else begin
      mag   = b ? int'($urandom_range(127, 1)) : -int'($urandom_range(128, 1));
      value = viterbi_pkg::soft_t'(mag);
    end
    return value;
  endfunction

  task automatic apply_reset();
    sys_rst       = 1'b1;
    soft_valid    = 1'b0;
    soft_in       = '0;
    enc_state     = '0;
    exp_q.delete();
    repeat (10) @(negedge clk);
    sys_rst = 1'b0;
  endtask

  // Hold the sample until the DUT takes it
  task automatic send_sample(input viterbi_pkg::soft_t value);
    int waited;
    waited = 0;
    if (!aborted) begin
      soft_in    = value;
      soft_valid = 1'b1;
      @(negedge clk);
      while (!in_take && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (!in_take) begin
        timeout_count++;
        aborted = 1'b1;
        $display("Timeout at %0t: the decoder accepted no sample for %0d cycles",
                 $time, WAIT_LIMIT);
      end
    end
  endtask

  task automatic send_bit(input logic b, input int weak_pct, input bit erase_on);
    logic [1:0] code;
    code      = viterbi_pkg::code_bits(enc_state, b);
    enc_state = {b, enc_state[viterbi_pkg::CONSTRAINT_LEN-2:1]};
    send_sample(soft_value(code[1], weak_pct, erase_on)); // I first
    send_sample(soft_value(code[0], weak_pct, erase_on));
  endtask

  // Block the sink until every stage holds data, then reset mid-flight
  task automatic reset_while_stalled();
    int i;
    int waited;
    if (!aborted) begin
      apply_reset();
      ready_low_pct = 100;
      for (i = 0; i < DECODE_DEPTH + 4; i++) begin
        send_bit(1'($urandom_range(1)), 0, 1'b0);
      end
      soft_valid = 1'b0;
      waited     = 0;
      while (!aborted && !(bit_valid && !soft_ready) && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (!aborted && !(bit_valid && !soft_ready)) begin
        timeout_count++;
        aborted = 1'b1;
        $display("Timeout at %0t: the stalled pipeline never filled up", $time);
      end
      apply_reset(); // Sink still blocked here
      ready_low_pct = 0;
    end
  endtask

  task automatic run_scenario(input int num_bits, input int weak_pct, input bit erase_on,
                              input int stall_pct);
    int   i;
    int   waited;
    logic b;
    if (!aborted) begin
      apply_reset();
      ready_low_pct = stall_pct;
      for (i = 0; i < num_bits; i++) begin
        b = 1'($urandom_range(1));
        exp_q.push_back(b);
        send_bit(b, weak_pct, erase_on);
      end
      // Tail flushes the last source bits out of the survivor paths
      for (i = 0; i < DECODE_DEPTH; i++) begin
        send_bit(1'b0, weak_pct, erase_on);
      end
      soft_valid = 1'b0;
      waited     = 0;
      while (!aborted && rd_idx < exp_q.size() && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (!aborted && rd_idx < exp_q.size()) begin
        timeout_count++;
        aborted = 1'b1;
        $display("Timeout at %0t: %0d decoded bits never arrived",
                 $time, exp_q.size() - rd_idx);
      end
    end
  endtask

  initial begin
    void'($urandom(81));
    sys_rst       = 1'b1;
    soft_in       = '0;
    soft_valid    = 1'b0;
    ready_low_pct = 0;
    timeout_count = 0;
    aborted       = 1'b0;
    enc_state     = '0;

    run_scenario(300, 0, 1'b0, 0);    // Clean stream
    reset_while_stalled();            // Full pipeline at reset
    run_scenario(300, 5, 1'b1, 0);    // Weak and erased samples
    run_scenario(300, 5, 1'b1, 40);   // Sink stalls
    run_scenario(3000, 100, 1'b0, 20); // Weak samples throughout so metrics keep climbing

    errors = timeout_count + uut.u_check.fail_count;
    $display("Summary: %0d bits decoded, %0d assertion failures, %0d timeouts, %0d errors",
             bits_out, uut.u_check.fail_count, timeout_count, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/viterbi_pkg.sv
rtl/branch_metric_if.sv
rtl/symbol_pair.sv
rtl/branch_metric.sv
rtl/acs_array.sv
rtl/survivor_exchange.sv
rtl/viterbi_top.sv
verif/viterbi_assert.sv
verif/tb_viterbi.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Viterbi decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_viterbi -f src.f -o tb_viterbi
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Keep running after assertion errors so the testbench prints its summary
./obj_dir/tb_viterbi +verilator+error+limit+100000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$log_file"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi
